/* filelist.f */
logic/lsu_isa_pkg.sv
logic/lsu_mem_pkg.sv
logic/lsu_decode.sv
logic/lsu_agu.sv
logic/lsu_store_align.sv
logic/lsu_load_stage.sv
logic/lsu_top.sv
dv/lsu_chk.sv
dv/lsu_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module lsu_tb -f filelist.f

sim:
	verilator --binary --timing --assert --top-module lsu_tb -Mdir obj_dir -f filelist.f
	-./obj_dir/Vlsu_tb > $(LOG) 2>&1
	cat $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

    logic        clk;
    logic        rst;
    logic        e1_flush;
    logic        in_valid;
    logic [15:0] in_raw;
    logic [31:0] in_r0;
    logic [31:0] in_gbr;
    logic [31:0] in_opl;
    logic [31:0] in_oph;
    logic [31:0] dm_req_addr;
    logic [63:0] dm_req_wdata;
    logic [7:0]  dm_req_wmask;
    logic        dm_req_wen;
    logic        dm_req_valid;
    logic [63:0] dm_resp_rdata;
    logic        dm_resp_valid;
    logic        e1_wen;
    logic        e1_wpending;
    logic [3:0]  e1_wdst;
    logic [31:0] e1_wdata;
    logic        e1_alt_wen;
    logic [3:0]  e1_alt_wdst;
    logic [31:0] e1_alt_wdata;
    logic        e2_wen;
    logic [3:0]  e2_wdst;
    logic [31:0] e2_wdata;
    logic        e2_nack;
    logic        e2_t_wen;
    logic        e2_t_value;

    logic        hold_resp;                 // Withhold the next response
    logic [63:0] mem [logic [28:0]];        // Sparse memory, one entry per bus word
    int          cycles;

    lsu_top uut (.*);

    always #4 clk = ~clk;                   // 8 ns period

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= 4000)
        begin
            $display("Timeout: simulation ran past 4000 cycles");
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    end

    // Untouched words read a pattern of their own address
    function automatic logic [63:0] mem_rd(input logic [28:0] idx);
        if (mem.exists(idx))
            return mem[idx];
        return {idx ^ 29'h0a5a5a5, 3'b101, ~idx, 3'b011};
    endfunction

    task automatic store_bytes(input logic [28:0] idx, input logic [63:0] wd,
                               input logic [7:0] wm);
        logic [63:0] w;
        w = mem_rd(idx);
        for (int i = 0; i < 8; i++)
            if (wm[i])
                w[i*8 +: 8] = wd[i*8 +: 8];
        mem[idx] = w;
    endtask

    // Memory answers in E2 and writes only when it answers
    always @(posedge clk)
    begin
        if (!rst && dm_req_valid)
        begin
            dm_resp_valid <= !hold_resp;
            dm_resp_rdata <= mem_rd(dm_req_addr[31:3]);
            if (dm_req_wen && !hold_resp)
                store_bytes(dm_req_addr[31:3], dm_req_wdata, dm_req_wmask);
        end
        else
            dm_resp_valid <= 1'b0;
    end

    // Sign-extended lane at the given offset
    function automatic logic [31:0] lane_ext(input logic [63:0] w, input logic [2:0] off,
                                             input int sz);
        logic [63:0] s;
        if (sz == 0)
        begin
            s = w >> (8 * off);
            return {{24{s[7]}}, s[7:0]};
        end
        if (sz == 1)
        begin
            s = w >> (16 * off[2:1]);
            return {{16{s[15]}}, s[15:0]};
        end
        s = w >> (32 * off[2]);
        return s[31:0];
    endfunction

    task automatic expect_true(input logic cond, input string msg);
        assert (cond === 1'b1)
        else
        begin
            $display("FAILED at %0t ns: %s", $time, msg);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic run_mov(input int mode, input int sz, input logic hold, input logic flush);
        logic [3:0]  rn;
        logic [3:0]  rm;
        logic [31:0] r0v;
        logic [31:0] gbrv;
        logic [31:0] opl;
        logic [31:0] oph;
        logic [31:0] step;
        logic [31:0] addr;
        logic [31:0] st;
        logic [31:0] ld;
        logic [7:0]  exp_mask;
        logic [63:0] exp_data;
        logic [15:0] raw;
        logic [3:0]  dst;
        logic        is_st;
        rn   = 4'($urandom);
        rm   = 4'($urandom);
        r0v  = $urandom & 32'h3f;
        gbrv = 32'h2000;
        opl  = 32'h1000 + ($urandom & 32'hff);
        oph  = 32'h1000 + ($urandom & 32'hff);
        step = 1 << sz;
        dst  = rn;
        case (mode)
            0:
            begin
                raw  = {4'b0010, rn, rm, 2'b00, 2'(sz)};
                addr = oph;
            end
            1:
            begin
                raw  = {4'b0110, rn, rm, 2'b00, 2'(sz)};
                addr = opl;
            end
            2:
            begin
                raw  = {4'b0010, rn, rm, 2'b01, 2'(sz)};
                addr = oph - step;
            end
            3:
            begin
                raw  = {4'b0110, rn, rm, 2'b01, 2'(sz)};
                addr = opl;
            end
            4:
            begin
                raw  = {4'b0000, rn, rm, 2'b01, 2'(sz)};
                addr = r0v + oph;
            end
            5:
            begin
                raw  = {4'b0000, rn, rm, 2'b11, 2'(sz)};
                addr = r0v + opl;
            end
            default:
            begin
                raw  = {5'b11000, 1'(mode == 7), 2'(sz), 8'(opl)};
                opl  = (opl & 32'hff) << sz;       // Scaled displacement
                addr = opl + gbrv;
                dst  = 4'd0;                       // GBR loads go to R0
            end
        endcase
        is_st = (mode % 2 == 0);
        st    = (mode == 6) ? r0v : opl;
        exp_mask = (sz == 0) ? 8'h01 << addr[2:0] :
                   (sz == 1) ? 8'h03 << {addr[2:1], 1'b0} : 8'h0f << {addr[2], 2'b00};
        exp_data = (sz == 0) ? {8{st[7:0]}} : (sz == 1) ? {4{st[15:0]}} : {2{st}};
        ld = lane_ext(mem_rd(addr[31:3]), addr[2:0], sz);

        @(posedge clk);
        in_valid  <= 1'b1;
        in_raw    <= raw;
        in_r0     <= r0v;
        in_gbr    <= gbrv;
        in_opl    <= opl;
        in_oph    <= oph;
        e1_flush  <= flush;
        hold_resp <= hold;
        @(negedge clk);
        if (flush)
            expect_true(!dm_req_valid, "flushed E1 still requests");
        else
        begin
            expect_true(dm_req_valid && dm_req_wen == is_st, "request strobe or direction");
            expect_true(dm_req_addr == addr, "request address");
            if (is_st)
                expect_true(dm_req_wmask == exp_mask && dm_req_wdata == exp_data,
                            "store lane mask or data");
            else
                expect_true(e1_wen && e1_wpending && e1_wdst == dst, "load E1 pending write");
        end
        expect_true(e1_wen == (!is_st || mode == 2) &&
                    e1_alt_wen == (mode == 3 && rm != rn), "E1 register write enables");
        if (mode == 2)
            expect_true(!e1_wpending && e1_wdst == rn && e1_wdata == oph - step,
                        "pre-decrement base write");
        if (mode == 3 && rm != rn)
            expect_true(e1_alt_wdst == rm && e1_alt_wdata == opl + step,
                        "post-increment base write");
        @(posedge clk);
        in_valid <= 1'b0;
        e1_flush <= 1'b0;
        @(negedge clk);
        expect_true(!dm_req_valid, "request without a valid instruction");
        if (flush)
            expect_true(!e2_wen && !e2_nack && !e2_t_wen, "flushed access reached E2");
        else if (is_st || hold)
            expect_true(e2_nack == hold && !e2_wen, "E2 nack or stray write-back");
        else
            expect_true(e2_wen && !e2_nack && e2_wdst == dst && e2_wdata == ld,
                        "load write-back");
    endtask

    // kind 0 AND, 1 OR, 2 XOR, 3 TST, 4 TAS
    task automatic run_amo(input int kind);
        logic [15:0] raw;
        logic [3:0]  rn;
        logic [7:0]  imm;
        logic [31:0] r0v;
        logic [31:0] gbrv;
        logic [31:0] rnv;
        logic [31:0] addr;
        logic [7:0]  old;
        logic [7:0]  newb;
        logic [7:0]  saved;
        logic        phase_wr;
        logic        done;
        logic        hold;
        rn   = 4'($urandom);
        imm  = 8'($urandom);
        r0v  = $urandom & 32'h3f;
        gbrv = 32'h3000;
        rnv  = 32'h3000 + ($urandom & 32'h3f);
        case (kind)
            0:       raw = {8'hcd, imm};
            1:       raw = {8'hcf, imm};
            2:       raw = {8'hce, imm};
            3:       raw = {8'hcc, imm};
            default: raw = {4'h4, rn, 8'h1b};
        endcase
        addr = (kind == 4) ? rnv : r0v + gbrv;
        if ($urandom % 3 == 0)
            store_bytes(addr[31:3], 64'h0, 8'h01 << addr[2:0]);   // Reach T = 1
        old = 8'(mem_rd(addr[31:3]) >> (8 * addr[2:0]));
        case (kind)
            0:       newb = old & imm;
            1:       newb = old | imm;
            2:       newb = old ^ imm;
            3:       newb = old;
            default: newb = old | 8'h80;
        endcase
        saved    = (kind == 3) ? old & imm : old;
        phase_wr = 1'b0;
        done     = 1'b0;
        while (!done)
        begin
            hold = ($urandom % 4 == 0);
            @(posedge clk);
            in_valid  <= 1'b1;
            in_raw    <= raw;
            in_r0     <= r0v;
            in_gbr    <= gbrv;
            in_opl    <= {24'h0, imm};
            in_oph    <= rnv;
            hold_resp <= hold;
            @(negedge clk);
            if (phase_wr && kind == 3)
                expect_true(!dm_req_valid, "TST second pass issued a request");
            else
            begin
                expect_true(dm_req_valid && dm_req_addr == addr && dm_req_wen == phase_wr,
                            "atomic request");
                if (phase_wr)
                    expect_true(dm_req_wmask == 8'h01 << addr[2:0] &&
                                dm_req_wdata == {8{newb}}, "atomic store byte");
            end
            @(posedge clk);
            in_valid <= 1'b0;
            @(negedge clk);
            expect_true(!e2_wen, "atomic raised register write-back");
            if (!phase_wr)
            begin
                expect_true(e2_nack && !e2_t_wen, "atomic first pass must nack");
                phase_wr = !hold;
            end
            else if (kind != 3 && hold)
                expect_true(e2_nack && !e2_t_wen, "atomic store without response");
            else
            begin
                expect_true(!e2_nack && e2_t_wen == (kind >= 3), "atomic second pass E2");
                if (kind >= 3)
                    expect_true(e2_t_value == (saved == 8'h00), "T bit value");
                done = 1'b1;
            end
        end
        expect_true(8'(mem_rd(addr[31:3]) >> (8 * addr[2:0])) == newb, "atomic memory result");
    endtask

    initial
    begin
        void'($urandom(81389));
        clk           = 1'b0;
        rst           = 1'b1;
        cycles        = 0;
        e1_flush      = 1'b0;
        in_valid      = 1'b0;
        in_raw        = 16'h0009;           // NOP
        in_r0         = '0;
        in_gbr        = '0;
        in_opl        = '0;
        in_oph        = '0;
        dm_resp_rdata = '0;
        dm_resp_valid = 1'b0;
        hold_resp     = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        expect_true(!e2_wen && !e2_nack && !e2_t_wen && !dm_req_valid, "outputs after reset");
        for (int i = 0; i < 500; i++)
            run_mov($urandom % 8, $urandom % 3, ($urandom % 5 == 0), ($urandom % 16 == 0));
        for (int k = 0; k < 5; k++)
            repeat (15) run_amo(k);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/lsu_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_chk (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            e1_flush,
    input  wire                            dm_req_valid,
    input  wire [7:0]                      dm_req_wmask,
    input  wire lsu_isa_pkg::access_size_e size,
    input  wire                            e2_wen,
    input  wire                            e2_nack,
    input  wire                            e2_t_wen
);

    // Lane count follows access width
    assert property (@(posedge clk) disable iff (rst)
        dm_req_valid |-> $countones(dm_req_wmask) ==
            ((size == lsu_isa_pkg::SZ_BYTE) ? 1 : (size == lsu_isa_pkg::SZ_WORD) ? 2 : 4))
    else $error("write mask width does not match access size");

    assert property (@(posedge clk) disable iff (rst) !(e2_nack && e2_wen))
    else $error("nack and write-back together");

    assert property (@(posedge clk) disable iff (rst) e1_flush |-> !dm_req_valid)
    else $error("request during flush");

    // First edge of reset still clears E2
    assert property (@(posedge clk) (rst && $past(rst)) |->
        !e2_wen && !e2_nack && !e2_t_wen && !dm_req_valid)
    else $error("control output active in reset");

endmodule

bind lsu_top lsu_chk u_chk (.*);

`default_nettype wire

/* logic/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  e1_flush,
    input  wire                                  in_valid,
    input  wire [15:0]                           in_raw,
    input  wire [lsu_mem_pkg::XLEN-1:0]          in_r0,
    input  wire [lsu_mem_pkg::XLEN-1:0]          in_gbr,
    input  wire [lsu_mem_pkg::XLEN-1:0]          in_opl,
    input  wire [lsu_mem_pkg::XLEN-1:0]          in_oph,
    output logic [lsu_mem_pkg::XLEN-1:0]         dm_req_addr,
    output logic [lsu_mem_pkg::BUS_W-1:0]        dm_req_wdata,
    output logic [lsu_mem_pkg::LANES-1:0]        dm_req_wmask,
    output logic                                 dm_req_wen,
    output logic                                 dm_req_valid,
    input  wire [lsu_mem_pkg::BUS_W-1:0]         dm_resp_rdata,
    input  wire                                  dm_resp_valid,
    output logic                                 e1_wen,
    output logic                                 e1_wpending,
    output logic [lsu_isa_pkg::REG_IDX_W-1:0]    e1_wdst,
    output logic [lsu_mem_pkg::XLEN-1:0]         e1_wdata,
    output logic                                 e1_alt_wen,
    output logic [lsu_isa_pkg::REG_IDX_W-1:0]    e1_alt_wdst,
    output logic [lsu_mem_pkg::XLEN-1:0]         e1_alt_wdata,
    output logic                                 e2_wen,
    output logic [lsu_isa_pkg::REG_IDX_W-1:0]    e2_wdst,
    output logic [lsu_mem_pkg::XLEN-1:0]         e2_wdata,
    output logic                                 e2_nack,
    output logic                                 e2_t_wen,
    output logic                                 e2_t_value
);

    lsu_isa_pkg::lsu_op_e       op;
    lsu_isa_pkg::access_size_e  size;
    lsu_isa_pkg::amo_phase_e    amo_phase;
    logic                       is_load;
    logic                       is_store;
    logic                       e1_live;      // Valid and not flushed
    logic [7:0]                 amo_old;
    logic [lsu_mem_pkg::XLEN-1:0] st_val;

    assign e1_live      = in_valid && !e1_flush;
    assign dm_req_valid = e1_live && (is_load || is_store);
    assign dm_req_wen   = is_store;

    lsu_decode u_decode (
        .in_raw    (in_raw),
        .amo_phase (amo_phase),
        .op        (op),
        .size      (size),
        .is_load   (is_load),
        .is_store  (is_store)
    );

    lsu_agu u_agu (
        .op           (op),
        .size         (size),
        .in_r0        (in_r0),
        .in_gbr       (in_gbr),
        .in_opl       (in_opl),
        .in_oph       (in_oph),
        .in_raw       (in_raw),
        .amo_old      (amo_old),
        .addr         (dm_req_addr),
        .st_val       (st_val),
        .e1_wen       (e1_wen),
        .e1_wpending  (e1_wpending),
        .e1_wdst      (e1_wdst),
        .e1_wdata     (e1_wdata),
        .e1_alt_wen   (e1_alt_wen),
        .e1_alt_wdst  (e1_alt_wdst),
        .e1_alt_wdata (e1_alt_wdata)
    );

    lsu_store_align u_store_align (
        .addr_off     (dm_req_addr[lsu_mem_pkg::OFFSET_W-1:0]),
        .size         (size),
        .st_val       (st_val),
        .dm_req_wmask (dm_req_wmask),
        .dm_req_wdata (dm_req_wdata)
    );

    lsu_load_stage u_load_stage (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (e1_live),
        .is_store      (is_store),
        .op            (op),
        .size          (size),
        .addr_off      (dm_req_addr[lsu_mem_pkg::OFFSET_W-1:0]),
        .e1_wdst       (e1_wdst),
        .in_opl        (in_opl[7:0]),
        .dm_resp_rdata (dm_resp_rdata),
        .dm_resp_valid (dm_resp_valid),
        .e2_wen        (e2_wen),
        .e2_wdst       (e2_wdst),
        .e2_wdata      (e2_wdata),
        .e2_nack       (e2_nack),
        .e2_t_wen      (e2_t_wen),
        .e2_t_value    (e2_t_value),
        .amo_phase     (amo_phase),
        .amo_old       (amo_old)
    );

endmodule

`default_nettype wire

/* logic/lsu_load_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_stage (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  req_valid,   // Live E1 instruction
    input  wire                                  is_store,
    input  wire lsu_isa_pkg::lsu_op_e            op,
    input  wire lsu_isa_pkg::access_size_e       size,
    input  wire [lsu_mem_pkg::OFFSET_W-1:0]      addr_off,
    input  wire [lsu_isa_pkg::REG_IDX_W-1:0]     e1_wdst,
    input  wire [7:0]                            in_opl,      // TST immediate
    input  wire [lsu_mem_pkg::BUS_W-1:0]         dm_resp_rdata,
    input  wire                                  dm_resp_valid,
    output logic                                 e2_wen,
    output logic [lsu_isa_pkg::REG_IDX_W-1:0]    e2_wdst,
    output logic [lsu_mem_pkg::XLEN-1:0]         e2_wdata,
    output logic                                 e2_nack,
    output logic                                 e2_t_wen,
    output logic                                 e2_t_value,
    output lsu_isa_pkg::amo_phase_e              amo_phase,
    output logic [7:0]                           amo_old
);

    logic                              e2_valid;      // Instruction sits in E2
    logic                              e2_store;
    lsu_isa_pkg::lsu_op_e              e2_op;
    lsu_isa_pkg::access_size_e         e2_size;
    lsu_isa_pkg::amo_phase_e           e2_phase;      // Pass this access belongs to
    logic [lsu_mem_pkg::OFFSET_W-1:0]  e2_off;
    logic [7:0]                        e2_imm;
    logic                              e2_amo;
    logic                              e2_sets_t;
    logic                              e2_needs_mem;
    logic                              resp_ok;
    logic [7:0]                        rd_byte;
    logic [15:0]                       rd_half;
    logic [31:0]                       rd_word;

    // TST second pass has no request but must still reach E2
    always_ff @(posedge clk)
    begin
        if (rst)
            e2_valid <= 1'b0;
        else
            e2_valid <= req_valid && (op != lsu_isa_pkg::OP_NONE);
    end

    always_ff @(posedge clk)
    begin
        e2_store <= is_store;
        e2_op    <= op;
        e2_size  <= size;
        e2_phase <= amo_phase;
        e2_off   <= addr_off;
        e2_imm   <= in_opl;
        e2_wdst  <= e1_wdst;
    end

    assign e2_amo = e2_op inside {lsu_isa_pkg::OP_AMO_AND, lsu_isa_pkg::OP_AMO_OR,
                                  lsu_isa_pkg::OP_AMO_XOR, lsu_isa_pkg::OP_AMO_TST,
                                  lsu_isa_pkg::OP_AMO_TAS};
    assign e2_sets_t = e2_op inside {lsu_isa_pkg::OP_AMO_TST, lsu_isa_pkg::OP_AMO_TAS};
    assign e2_needs_mem = !((e2_op == lsu_isa_pkg::OP_AMO_TST) &&
                            (e2_phase == lsu_isa_pkg::AMO_WRITE));
    assign resp_ok = dm_resp_valid || !e2_needs_mem;   // TST write pass never waits

    // Lane select at the saved offset
    assign rd_byte = dm_resp_rdata[{e2_off, 3'b000} +: 8];
    assign rd_half = dm_resp_rdata[{e2_off[lsu_mem_pkg::OFFSET_W-1:1], 4'b0000} +: 16];
    assign rd_word = dm_resp_rdata[{e2_off[lsu_mem_pkg::OFFSET_W-1], 5'b00000} +: 32];

    always_comb
    begin
        case (e2_size)
            lsu_isa_pkg::SZ_WORD: e2_wdata = {{16{rd_half[15]}}, rd_half};  // Sign extend
            lsu_isa_pkg::SZ_LONG: e2_wdata = rd_word;
            default:              e2_wdata = {{24{rd_byte[7]}}, rd_byte};
        endcase
    end

    // First atomic pass always replays, any missing response replays
    assign e2_nack = e2_valid && (!resp_ok ||
                     (e2_amo && (e2_phase == lsu_isa_pkg::AMO_READ)));
    assign e2_wen = e2_valid && dm_resp_valid && !e2_store && !e2_amo;  // Plain loads only
    assign e2_t_wen = e2_valid && e2_sets_t && resp_ok &&
                      (e2_phase == lsu_isa_pkg::AMO_WRITE);
    assign e2_t_value = (amo_old == 8'h00);

    // Atomic pass FSM, a write pass without response holds in AMO_WRITE
    always_ff @(posedge clk)
    begin
        if (rst)
            amo_phase <= lsu_isa_pkg::AMO_READ;
        else if (e2_valid && e2_amo)
        begin
            if ((e2_phase == lsu_isa_pkg::AMO_READ) && dm_resp_valid)
                amo_phase <= lsu_isa_pkg::AMO_WRITE;
            else if ((e2_phase == lsu_isa_pkg::AMO_WRITE) && resp_ok)
                amo_phase <= lsu_isa_pkg::AMO_READ;
        end
    end

    always_ff @(posedge clk)
    begin
        if (e2_valid && e2_amo && (e2_phase == lsu_isa_pkg::AMO_READ) && dm_resp_valid)
            amo_old <= rd_byte & ((e2_op == lsu_isa_pkg::OP_AMO_TST) ? e2_imm : 8'hff);
    end

endmodule

`default_nettype wire

/* logic/lsu_store_align.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_store_align (
    input  wire [lsu_mem_pkg::OFFSET_W-1:0]  addr_off,
    input  wire lsu_isa_pkg::access_size_e   size,
    input  wire [lsu_mem_pkg::XLEN-1:0]      st_val,
    output logic [lsu_mem_pkg::LANES-1:0]    dm_req_wmask,
    output logic [lsu_mem_pkg::BUS_W-1:0]    dm_req_wdata
);

    always_comb
    begin
        case (size)
            lsu_isa_pkg::SZ_WORD:
            begin
                // Aligned lane pair, low offset bit ignored
                dm_req_wmask = {{(lsu_mem_pkg::LANES-2){1'b0}}, 2'b11}
                               << {addr_off[lsu_mem_pkg::OFFSET_W-1:1], 1'b0};
                dm_req_wdata = {(lsu_mem_pkg::LANES/2){st_val[15:0]}};
            end
            lsu_isa_pkg::SZ_LONG:
            begin
                // Upper or lower four lanes
                dm_req_wmask = {{(lsu_mem_pkg::LANES-4){1'b0}}, 4'hf}
                               << {addr_off[lsu_mem_pkg::OFFSET_W-1], 2'b00};
                dm_req_wdata = {(lsu_mem_pkg::LANES/4){st_val[31:0]}};
            end
            default:
            begin
                dm_req_wmask = {{(lsu_mem_pkg::LANES-1){1'b0}}, 1'b1} << addr_off;
                dm_req_wdata = {lsu_mem_pkg::LANES{st_val[7:0]}};  // Byte on every lane
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/lsu_agu.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_agu (
    input  wire lsu_isa_pkg::lsu_op_e                op,
    input  wire lsu_isa_pkg::access_size_e           size,
    input  wire [lsu_mem_pkg::XLEN-1:0]              in_r0,
    input  wire [lsu_mem_pkg::XLEN-1:0]              in_gbr,
    input  wire [lsu_mem_pkg::XLEN-1:0]              in_opl,     // Rm, imm or scaled disp
    input  wire [lsu_mem_pkg::XLEN-1:0]              in_oph,     // Rn
    input  wire [15:0]                               in_raw,
    input  wire [7:0]                                amo_old,
    output logic [lsu_mem_pkg::XLEN-1:0]             addr,
    output logic [lsu_mem_pkg::XLEN-1:0]             st_val,
    output logic                                     e1_wen,
    output logic                                     e1_wpending,
    output logic [lsu_isa_pkg::REG_IDX_W-1:0]        e1_wdst,
    output logic [lsu_mem_pkg::XLEN-1:0]             e1_wdata,
    output logic                                     e1_alt_wen,
    output logic [lsu_isa_pkg::REG_IDX_W-1:0]        e1_alt_wdst,
    output logic [lsu_mem_pkg::XLEN-1:0]             e1_alt_wdata
);

    logic [lsu_isa_pkg::REG_IDX_W-1:0] rn;      // Destination / base field
    logic [lsu_isa_pkg::REG_IDX_W-1:0] rm;      // Source field
    logic [lsu_mem_pkg::XLEN-1:0]      step;    // Access size in bytes
    logic [lsu_mem_pkg::XLEN-1:0]      rn_dec;
    logic [lsu_mem_pkg::XLEN-1:0]      rm_inc;
    logic [7:0]                        amo_new; // Byte stored by the second pass

    assign rn = in_raw[11:8];
    assign rm = in_raw[7:4];

    always_comb
    begin
        case (size)
            lsu_isa_pkg::SZ_WORD: step = 2;
            lsu_isa_pkg::SZ_LONG: step = 4;
            default:              step = 1;
        endcase
    end

    assign rn_dec = in_oph - step;
    assign rm_inc = in_opl + step;

    always_comb
    begin
        case (op)
            lsu_isa_pkg::OP_AMO_AND: amo_new = amo_old & in_opl[7:0];
            lsu_isa_pkg::OP_AMO_OR:  amo_new = amo_old | in_opl[7:0];
            lsu_isa_pkg::OP_AMO_XOR: amo_new = amo_old ^ in_opl[7:0];
            default:                 amo_new = amo_old | lsu_isa_pkg::AMO_SET_BIT; // TAS
        endcase
    end

    always_comb
    begin
        addr         = in_oph;                  // @Rn unless changed below
        st_val       = in_opl;                  // Rm for register stores
        e1_wen       = 1'b0;
        e1_wpending  = 1'b0;
        e1_wdst      = rn;
        e1_wdata     = rn_dec;
        e1_alt_wen   = 1'b0;
        e1_alt_wdst  = rm;
        e1_alt_wdata = rm_inc;
        case (op)
            lsu_isa_pkg::OP_LD_RM,
            lsu_isa_pkg::OP_LD_R0RM,
            lsu_isa_pkg::OP_LD_POSTINC:
            begin
                addr        = (op == lsu_isa_pkg::OP_LD_R0RM) ? in_r0 + in_opl : in_opl;
                e1_wen      = 1'b1;
                e1_wpending = 1'b1;             // Data arrives in E2
                e1_alt_wen  = (op == lsu_isa_pkg::OP_LD_POSTINC) && (rm != rn); // Load wins
            end
            lsu_isa_pkg::OP_ST_PREDEC:
            begin
                addr   = rn_dec;
                e1_wen = 1'b1;                  // Updated Rn ready now
            end
            lsu_isa_pkg::OP_ST_R0RN: addr = in_r0 + in_oph;
            lsu_isa_pkg::OP_ST_GBR:
            begin
                addr   = in_opl + in_gbr;
                st_val = in_r0;
            end
            lsu_isa_pkg::OP_LD_GBR:
            begin
                addr        = in_opl + in_gbr;
                e1_wen      = 1'b1;
                e1_wpending = 1'b1;
                e1_wdst     = '0;               // Always R0
            end
            lsu_isa_pkg::OP_AMO_AND,
            lsu_isa_pkg::OP_AMO_OR,
            lsu_isa_pkg::OP_AMO_XOR,
            lsu_isa_pkg::OP_AMO_TST:
            begin
                addr   = in_r0 + in_gbr;
                st_val = {{(lsu_mem_pkg::XLEN-8){1'b0}}, amo_new};
            end
            lsu_isa_pkg::OP_AMO_TAS: st_val = {{(lsu_mem_pkg::XLEN-8){1'b0}}, amo_new};
            default:                 addr = in_oph;
        endcase
    end

endmodule

`default_nettype wire

/* logic/lsu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_decode (
    input  wire [15:0]                   in_raw,
    input  wire lsu_isa_pkg::amo_phase_e amo_phase,
    output lsu_isa_pkg::lsu_op_e         op,
    output lsu_isa_pkg::access_size_e    size,
    output logic                         is_load,
    output logic                         is_store
);

    logic [1:0] sz_bits;    // Raw size field of the matched form

    always_comb
    begin
        casez (in_raw)
            16'b0010????????00??: op = lsu_isa_pkg::OP_ST_RN;       // Rm,@Rn
            16'b0110????????00??: op = lsu_isa_pkg::OP_LD_RM;       // @Rm,Rn
            16'b0010????????01??: op = lsu_isa_pkg::OP_ST_PREDEC;   // Rm,@-Rn
            16'b0110????????01??: op = lsu_isa_pkg::OP_LD_POSTINC;  // @Rm+,Rn
            16'b0000????????01??: op = lsu_isa_pkg::OP_ST_R0RN;     // Rm,@(R0,Rn)
            16'b0000????????11??: op = lsu_isa_pkg::OP_LD_R0RM;     // @(R0,Rm),Rn
            16'b110000??????????: op = lsu_isa_pkg::OP_ST_GBR;      // R0,@(disp,GBR)
            16'b110001??????????: op = lsu_isa_pkg::OP_LD_GBR;      // @(disp,GBR),R0
            16'b11001100????????: op = lsu_isa_pkg::OP_AMO_TST;
            16'b11001101????????: op = lsu_isa_pkg::OP_AMO_AND;
            16'b11001110????????: op = lsu_isa_pkg::OP_AMO_XOR;
            16'b11001111????????: op = lsu_isa_pkg::OP_AMO_OR;
            16'b0100????00011011: op = lsu_isa_pkg::OP_AMO_TAS;
            default:              op = lsu_isa_pkg::OP_NONE;
        endcase

        // GBR forms carry size in bits 9:8, register forms in bits 1:0
        case (op)
            lsu_isa_pkg::OP_ST_GBR,
            lsu_isa_pkg::OP_LD_GBR:  sz_bits = in_raw[9:8];
            lsu_isa_pkg::OP_AMO_AND,
            lsu_isa_pkg::OP_AMO_OR,
            lsu_isa_pkg::OP_AMO_XOR,
            lsu_isa_pkg::OP_AMO_TST,
            lsu_isa_pkg::OP_AMO_TAS: sz_bits = 2'b00;     // Atomics are byte only
            default:                 sz_bits = in_raw[1:0];
        endcase

        size = lsu_isa_pkg::access_size_e'(sz_bits);
        if (sz_bits == 2'b11)
        begin
            op   = lsu_isa_pkg::OP_NONE;                   // MUL.L, MOVA, TRAPA etc
            size = lsu_isa_pkg::SZ_BYTE;
        end
    end

    // Memory intent, atomics follow the current pass
    always_comb
    begin
        is_load  = 1'b0;
        is_store = 1'b0;
        case (op)
            lsu_isa_pkg::OP_LD_RM,
            lsu_isa_pkg::OP_LD_POSTINC,
            lsu_isa_pkg::OP_LD_R0RM,
            lsu_isa_pkg::OP_LD_GBR:  is_load = 1'b1;
            lsu_isa_pkg::OP_ST_RN,
            lsu_isa_pkg::OP_ST_PREDEC,
            lsu_isa_pkg::OP_ST_R0RN,
            lsu_isa_pkg::OP_ST_GBR:  is_store = 1'b1;
            lsu_isa_pkg::OP_AMO_TST: is_load = (amo_phase == lsu_isa_pkg::AMO_READ); // Never stores
            lsu_isa_pkg::OP_AMO_AND,
            lsu_isa_pkg::OP_AMO_OR,
            lsu_isa_pkg::OP_AMO_XOR,
            lsu_isa_pkg::OP_AMO_TAS:
            begin
                is_load  = (amo_phase == lsu_isa_pkg::AMO_READ);
                is_store = (amo_phase == lsu_isa_pkg::AMO_WRITE);
            end
            default:                 is_load = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/lsu_mem_pkg.sv */
`default_nettype none

package lsu_mem_pkg;

    localparam int XLEN     = 32;   // Register and address width
    localparam int BUS_W    = 64;   // Data memory bus width
    localparam int LANES    = 8;    // Byte lanes on the bus
    localparam int OFFSET_W = 3;    // Byte offset inside one bus word

endpackage

`default_nettype wire

/* logic/lsu_isa_pkg.sv */
`default_nettype none

package lsu_isa_pkg;

    localparam int REG_IDX_W = 4;                 // General register number
    localparam logic [7:0] AMO_SET_BIT = 8'h80;   // Lock bit written by TAS.B

    // Operation after decode, one per addressing mode or atomic kind
    typedef enum logic [3:0] {
        OP_NONE,          // Not handled by the LSU
        OP_ST_RN,         // MOV.x Rm,@Rn
        OP_LD_RM,         // MOV.x @Rm,Rn
        OP_ST_PREDEC,     // MOV.x Rm,@-Rn
        OP_LD_POSTINC,    // MOV.x @Rm+,Rn
        OP_ST_R0RN,       // MOV.x Rm,@(R0,Rn)
        OP_LD_R0RM,       // MOV.x @(R0,Rm),Rn
        OP_ST_GBR,        // MOV.x R0,@(disp,GBR)
        OP_LD_GBR,        // MOV.x @(disp,GBR),R0
        OP_AMO_AND,       // AND.B #imm,@(R0,GBR)
        OP_AMO_OR,        // OR.B #imm,@(R0,GBR)
        OP_AMO_XOR,       // XOR.B #imm,@(R0,GBR)
        OP_AMO_TST,       // TST.B #imm,@(R0,GBR)
        OP_AMO_TAS        // TAS.B @Rn
    } lsu_op_e;

    // Same code as the size field of the MOV encodings
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,   // 8 bit
        SZ_WORD = 2'd1,   // 16 bit
        SZ_LONG = 2'd2    // 32 bit
    } access_size_e;

    // Two passes of a read-modify-write
    typedef enum logic {
        AMO_READ  = 1'b0, // Fetch old byte, always replayed
        AMO_WRITE = 1'b1  // Store new byte or report T
    } amo_phase_e;

endpackage

`default_nettype wire
